// File: dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// Byte address and data word
`define DCACHE_ADDR_BITS 16
`define DCACHE_WORD_BITS 32

// Cache geometry
`define DCACHE_WORDS 4
`define DCACHE_SETS 16

// Core transaction id
`define DCACHE_TID_BITS 4

// Address split into tag, set and line offset
`define DCACHE_OFFSET_BITS ($clog2(`DCACHE_WORDS * `DCACHE_WORD_BITS / 8))
`define DCACHE_SET_BITS ($clog2(`DCACHE_SETS))
`define DCACHE_TAG_BITS \
    (`DCACHE_ADDR_BITS - `DCACHE_OFFSET_BITS - `DCACHE_SET_BITS)

`endif

// File: dcache_pkg.sv
`include "dcache_params.svh"

package dcache_pkg;

    typedef enum logic {
        DCACHE_LOAD  = 1'b0,
        DCACHE_STORE = 1'b1
    } dcache_op_e;

    typedef logic [`DCACHE_ADDR_BITS-1:0]                      dcache_addr_t;
    typedef logic [`DCACHE_WORD_BITS-1:0]                      dcache_data_t;
    typedef logic [`DCACHE_WORD_BITS/8-1:0]                    dcache_be_t;
    typedef logic [`DCACHE_TID_BITS-1:0]                       dcache_tid_t;
    typedef logic [`DCACHE_SET_BITS-1:0]                       dcache_set_t;
    typedef logic [`DCACHE_TAG_BITS-1:0]                       dcache_tag_t;
    typedef logic [$clog2(`DCACHE_WORDS)-1:0]                  dcache_word_t;
    typedef logic [`DCACHE_ADDR_BITS-`DCACHE_OFFSET_BITS-1:0] dcache_nline_t;

    typedef struct packed {
        dcache_op_e   op;
        dcache_addr_t addr;
        dcache_data_t wdata;
        dcache_be_t   be;
        dcache_tid_t  tid;
        logic         need_rsp;
    } dcache_req_t;

    typedef struct packed {
        dcache_data_t rdata;
        dcache_tid_t  tid;
    } dcache_rsp_t;

    typedef struct packed {
        logic        valid;
        dcache_tag_t tag;
    } dcache_dir_entry_t;

    typedef dcache_data_t [`DCACHE_WORDS-1:0] dcache_line_t;

    typedef struct packed {
        dcache_nline_t nline;
        dcache_tid_t   tid;
        dcache_word_t  word;
    } dcache_miss_t;

    // Refill line, plus the id and word of the load that waits for it
    typedef struct packed {
        dcache_nline_t nline;
        dcache_line_t  line;
        dcache_tid_t   tid;
        dcache_word_t  word;
    } dcache_refill_t;

    typedef struct packed {
        dcache_addr_t addr;
        dcache_data_t data;
        dcache_be_t   be;
    } dcache_wbuf_t;

    typedef struct packed {
        dcache_req_t  req;
        dcache_tag_t  tag;
        dcache_set_t  set;
        dcache_word_t word;
    } dcache_st1_t;

endpackage

// File: dcache_ram.sv
`timescale 1ns/1ps

module dcache_ram #(
    parameter type         entry_t = logic,
    parameter int unsigned DEPTH   = 16,
    localparam int unsigned AW     = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic          clk_i,

    input  logic          rd_en_i,
    input  logic [AW-1:0] rd_addr_i,
    output entry_t        rd_data_o,

    input  logic          wr_en_i,
    input  logic [AW-1:0] wr_addr_i,
    input  entry_t        wr_data_i
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Write-first: a read of the address being written sees the new entry
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            if (wr_en_i && (wr_addr_i == rd_addr_i)) begin
                rd_data_o <= wr_data_i;
            end else begin
                rd_data_o <= mem[rd_addr_i];
            end
        end
    end

endmodule

// File: dcache_req_arbiter.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_req_arbiter (
    input  logic                    clk_i,
    input  logic                    rst_ni,

    input  logic                    core_req_valid_i,
    input  dcache_pkg::dcache_req_t core_req_i,
    output logic                    core_req_ready_o,

    input  logic                    refill_valid_i,
    input  logic                    st1_hold_i,
    input  logic                    miss_busy_i,

    output logic                    rd_en_o,
    output dcache_pkg::dcache_set_t rd_set_o,

    output logic                    st1_valid_o,
    output dcache_pkg::dcache_st1_t st1_o
);

    import dcache_pkg::*;

    logic        init_q;
    logic        accept;
    logic        st1_valid_q;
    dcache_st1_t st1_q;

    // Ready rises one cycle after reset is released
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_q <= 1'b0;
        end else begin
            init_q <= 1'b1;
        end
    end

    // Refill owns the array write port in its cycle
    assign core_req_ready_o = init_q & ~refill_valid_i & ~st1_hold_i & ~miss_busy_i;
    assign accept           = core_req_valid_i & core_req_ready_o;

    assign rd_en_o  = accept;
    assign rd_set_o = core_req_i.addr[`DCACHE_OFFSET_BITS +: `DCACHE_SET_BITS];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            st1_valid_q <= 1'b0;
        end else begin
            st1_valid_q <= accept | (st1_valid_q & st1_hold_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            st1_q.req  <= core_req_i;
            st1_q.tag  <= core_req_i.addr[`DCACHE_ADDR_BITS-1 -: `DCACHE_TAG_BITS];
            st1_q.set  <= core_req_i.addr[`DCACHE_OFFSET_BITS +: `DCACHE_SET_BITS];
            st1_q.word <= core_req_i.addr[`DCACHE_OFFSET_BITS-1 -: $bits(dcache_word_t)];
        end
    end

    assign st1_valid_o = st1_valid_q;
    assign st1_o       = st1_q;

endmodule

// File: dcache_lookup.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_lookup (
    input  logic                       clk_i,
    input  logic                       rst_ni,

    input  logic                       rd_en_i,
    input  dcache_pkg::dcache_set_t    rd_set_i,

    input  logic                       st1_valid_i,
    input  dcache_pkg::dcache_st1_t    st1_i,
    input  logic                       st1_hold_i,

    input  logic                       refill_valid_i,
    input  dcache_pkg::dcache_refill_t refill_i,

    output logic                       hit_o,
    output dcache_pkg::dcache_line_t   rd_line_o
);

    import dcache_pkg::*;

    logic [`DCACHE_SETS-1:0] valid_q;
    logic                    held_q;
    dcache_dir_entry_t       dir_rd;
    dcache_dir_entry_t       dir_wr;
    dcache_set_t             refill_set;
    logic                    store_wr;
    dcache_line_t            merged_line;
    logic                    data_wr_en;
    dcache_set_t             data_wr_set;
    dcache_line_t            data_wr_line;

    assign refill_set   = refill_i.nline[`DCACHE_SET_BITS-1:0];
    assign dir_wr.valid = 1'b1;
    assign dir_wr.tag   = refill_i.nline[`DCACHE_SET_BITS +: `DCACHE_TAG_BITS];

    dcache_ram #(
        .entry_t (dcache_dir_entry_t),
        .DEPTH   (`DCACHE_SETS)
    ) dir_ram_i (
        .clk_i,
        .rd_en_i   (rd_en_i),
        .rd_addr_i (rd_set_i),
        .rd_data_o (dir_rd),
        .wr_en_i   (refill_valid_i),
        .wr_addr_i (refill_set),
        .wr_data_i (dir_wr)
    );

    // Per-set valid bits, the only directory state cleared by reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            held_q  <= 1'b0;
        end else begin
            if (refill_valid_i) begin
                valid_q[refill_set] <= 1'b1;
            end
            held_q <= st1_hold_i;
        end
    end

    assign hit_o = st1_valid_i & valid_q[st1_i.set] & dir_rd.valid
                 & (dir_rd.tag == st1_i.tag);

    // Store bytes merged into the word of the line just read
    always_comb begin
        merged_line = rd_line_o;
        for (int b = 0; b < `DCACHE_WORD_BITS / 8; b++) begin
            if (st1_i.req.be[b]) begin
                merged_line[st1_i.word][8*b +: 8] = st1_i.req.wdata[8*b +: 8];
            end
        end
    end

    // Written once, on the first stage 1 cycle of a store hit
    assign store_wr = hit_o & (st1_i.req.op == DCACHE_STORE) & ~held_q;

    assign data_wr_en   = refill_valid_i | store_wr;
    assign data_wr_set  = refill_valid_i ? refill_set : st1_i.set;
    assign data_wr_line = refill_valid_i ? refill_i.line : merged_line;

    dcache_ram #(
        .entry_t (dcache_line_t),
        .DEPTH   (`DCACHE_SETS)
    ) data_ram_i (
        .clk_i,
        .rd_en_i   (rd_en_i),
        .rd_addr_i (rd_set_i),
        .rd_data_o (rd_line_o),
        .wr_en_i   (data_wr_en),
        .wr_addr_i (data_wr_set),
        .wr_data_i (data_wr_line)
    );

endmodule

// File: dcache_rsp_miss.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_rsp_miss (
    input  logic                       clk_i,
    input  logic                       rst_ni,

    input  logic                       st1_valid_i,
    input  dcache_pkg::dcache_st1_t    st1_i,
    input  logic                       hit_i,
    input  dcache_pkg::dcache_line_t   rd_line_i,

    input  logic                       refill_valid_i,
    input  dcache_pkg::dcache_refill_t refill_i,

    output logic                       st1_hold_o,
    output logic                       miss_busy_o,

    output logic                       miss_valid_o,
    output dcache_pkg::dcache_miss_t   miss_o,
    input  logic                       miss_ready_i,

    output logic                       wbuf_write_o,
    output dcache_pkg::dcache_wbuf_t   wbuf_o,
    input  logic                       wbuf_ready_i,

    output logic                       core_rsp_valid_o,
    output dcache_pkg::dcache_rsp_t    core_rsp_o
);

    import dcache_pkg::*;

    logic         st1_load;
    logic         st1_store;
    logic         st1_miss;
    logic         miss_valid_q;
    logic         miss_busy_q;
    logic         miss_need_rsp_q;
    dcache_miss_t miss_q;
    logic         refill_rsp;
    logic         load_rsp;
    logic         store_rsp;

    assign st1_load  = st1_valid_i & (st1_i.req.op == DCACHE_LOAD);
    assign st1_store = st1_valid_i & (st1_i.req.op == DCACHE_STORE);
    assign st1_miss  = st1_load & ~hit_i;

    // Stage 2 miss register
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            miss_valid_q <= 1'b0;
            miss_busy_q  <= 1'b0;
        end else if (st1_miss) begin
            miss_valid_q <= 1'b1;
            miss_busy_q  <= 1'b1;
        end else begin
            if (miss_valid_q && miss_ready_i) begin
                miss_valid_q <= 1'b0;
            end
            if (refill_valid_i) begin
                miss_busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (st1_miss) begin
            miss_q.nline    <= st1_i.req.addr[`DCACHE_ADDR_BITS-1:`DCACHE_OFFSET_BITS];
            miss_q.tid      <= st1_i.req.tid;
            miss_q.word     <= st1_i.word;
            miss_need_rsp_q <= st1_i.req.need_rsp;
        end
    end

    assign miss_valid_o = miss_valid_q;
    assign miss_o       = miss_q;
    // Also blocks the core during the miss cycle itself
    assign miss_busy_o  = miss_busy_q | st1_miss;

    // Write-through of every store
    assign wbuf_write_o = st1_store;
    assign wbuf_o.addr  = st1_i.req.addr;
    assign wbuf_o.data  = st1_i.req.wdata;
    assign wbuf_o.be    = st1_i.req.be;
    assign st1_hold_o   = st1_store & ~wbuf_ready_i;

    assign refill_rsp = refill_valid_i & miss_need_rsp_q;
    assign load_rsp   = st1_load & hit_i & st1_i.req.need_rsp;
    assign store_rsp  = st1_store & wbuf_ready_i & st1_i.req.need_rsp;

    assign core_rsp_valid_o = refill_rsp | load_rsp | store_rsp;

    always_comb begin
        if (refill_valid_i) begin
            core_rsp_o.rdata = refill_i.line[refill_i.word];
            core_rsp_o.tid   = refill_i.tid;
        end else if (st1_load) begin
            core_rsp_o.rdata = rd_line_i[st1_i.word];
            core_rsp_o.tid   = st1_i.req.tid;
        end else begin
            core_rsp_o.rdata = '0;
            core_rsp_o.tid   = st1_i.req.tid;
        end
    end

endmodule

// File: dcache_ctrl_top.sv
`timescale 1ns/1ps

module dcache_ctrl_top (
    input  logic                       clk_i,
    input  logic                       rst_ni,

    input  logic                       core_req_valid_i,
    input  dcache_pkg::dcache_req_t    core_req_i,
    output logic                       core_req_ready_o,

    output logic                       core_rsp_valid_o,
    output dcache_pkg::dcache_rsp_t    core_rsp_o,

    output logic                       miss_valid_o,
    output dcache_pkg::dcache_miss_t   miss_o,
    input  logic                       miss_ready_i,

    input  logic                       refill_valid_i,
    input  dcache_pkg::dcache_refill_t refill_i,

    output logic                       wbuf_write_o,
    output dcache_pkg::dcache_wbuf_t   wbuf_o,
    input  logic                       wbuf_ready_i,

    output logic                       ctrl_empty_o
);

    import dcache_pkg::*;

    logic         st1_valid;
    dcache_st1_t  st1;
    logic         rd_en;
    dcache_set_t  rd_set;
    logic         hit;
    dcache_line_t rd_line;
    logic         st1_hold;
    logic         miss_busy;

    dcache_req_arbiter arbiter_i (
        .clk_i,
        .rst_ni,
        .core_req_valid_i,
        .core_req_i,
        .core_req_ready_o,
        .refill_valid_i,
        .st1_hold_i  (st1_hold),
        .miss_busy_i (miss_busy),
        .rd_en_o     (rd_en),
        .rd_set_o    (rd_set),
        .st1_valid_o (st1_valid),
        .st1_o       (st1)
    );

    dcache_lookup lookup_i (
        .clk_i,
        .rst_ni,
        .rd_en_i     (rd_en),
        .rd_set_i    (rd_set),
        .st1_valid_i (st1_valid),
        .st1_i       (st1),
        .st1_hold_i  (st1_hold),
        .refill_valid_i,
        .refill_i,
        .hit_o       (hit),
        .rd_line_o   (rd_line)
    );

    dcache_rsp_miss rsp_miss_i (
        .clk_i,
        .rst_ni,
        .st1_valid_i (st1_valid),
        .st1_i       (st1),
        .hit_i       (hit),
        .rd_line_i   (rd_line),
        .refill_valid_i,
        .refill_i,
        .st1_hold_o  (st1_hold),
        .miss_busy_o (miss_busy),
        .miss_valid_o,
        .miss_o,
        .miss_ready_i,
        .wbuf_write_o,
        .wbuf_o,
        .wbuf_ready_i,
        .core_rsp_valid_o,
        .core_rsp_o
    );

    assign ctrl_empty_o = ~(st1_valid | miss_busy);

endmodule

// File: tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    import dcache_pkg::*;

    localparam int MAX_LINES = 64;

    typedef struct packed {
        logic [3:0]  tid;
        logic [31:0] rdata;
        logic [63:0] due;
    } exp_rsp_t;

    bit             clk_i;
    logic           rst_ni;
    logic           core_req_valid_i;
    dcache_req_t    core_req_i;
    logic           core_req_ready_o;
    logic           core_rsp_valid_o;
    dcache_rsp_t    core_rsp_o;
    logic           miss_valid_o;
    dcache_miss_t   miss_o;
    logic           miss_ready_i;
    logic           refill_valid_i;
    dcache_refill_t refill_i;
    logic           wbuf_write_o;
    dcache_wbuf_t   wbuf_o;
    logic           wbuf_ready_i;
    logic           ctrl_empty_o;

    logic [31:0]  stim [0:8*MAX_LINES-1];
    logic [31:0]  shadow [0:16383];
    exp_rsp_t     exp_rsp_q [$];
    dcache_miss_t exp_miss_q [$];
    dcache_wbuf_t exp_wbuf_q [$];
    int           n_lines;
    int           n_need_rsp;
    int           rsp_count;
    int           cycle_cnt;
    int           cycle_limit;

    dcache_ctrl_top dut_i (.*);

    initial begin
        forever #20 clk_i = ~clk_i;
    end

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("Error: %0t ns: %s: got %h, expected %h", $time, msg, actual, expected);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] field(input int k, input int f);
        return stim[9'(8*k+f)];
    endfunction

    // One request per stimulus line, held until accepted
    task automatic drive_line(input int k);
        dcache_req_t req;
        exp_rsp_t    e;
        logic        exp_hit;
        logic        accepted;
        req.op       = dcache_op_e'(1'(field(k, 0)));
        req.addr     = 16'(field(k, 1));
        req.wdata    = field(k, 2);
        req.be       = 4'(field(k, 3));
        req.tid      = 4'(field(k, 4));
        req.need_rsp = 1'(field(k, 5));
        exp_hit      = 1'(field(k, 6));
        core_req_valid_i = 1'b1;
        core_req_i       = req;
        accepted         = 1'b0;
        while (!accepted) begin
            @(posedge clk_i);
            accepted = core_req_ready_o;
        end
        if (req.need_rsp) begin
            e.tid   = req.tid;
            e.rdata = field(k, 7);
            // Load hits answer in the very next cycle
            e.due   = (req.op == DCACHE_LOAD && exp_hit) ? 64'($time) + 64'd40 : 64'd0;
            exp_rsp_q.push_back(e);
        end
        if (req.op == DCACHE_STORE) begin
            exp_wbuf_q.push_back({req.addr, req.wdata, req.be});
        end else if (!exp_hit) begin
            exp_miss_q.push_back({req.addr[15:4], req.tid, req.addr[3:2]});
        end
        @(negedge clk_i);
        check_value(64'(ctrl_empty_o), 64'd0, "ctrl_empty_o with a request in stage 1");
        core_req_valid_i = 1'b0;
    endtask

    initial begin
        core_req_valid_i = 1'b0;
        core_req_i       = '0;
        miss_ready_i     = 1'b0;
        refill_valid_i   = 1'b0;
        refill_i         = '0;
        wbuf_ready_i     = 1'b0;
        rst_ni           = 1'b0;
        n_need_rsp       = 0;
        rsp_count        = 0;
        cycle_limit      = 0;
        void'($urandom(59239));
        for (int i = 0; i < 16384; i++) begin
            shadow[i] = {16'hC0DE, 2'b00, 14'(i)};
        end
        for (int i = 0; i < 8*MAX_LINES; i++) begin
            stim[i] = 32'hFFFF_FFFF;
        end
        $readmemh("dcache_stimulus.txt", stim);
        n_lines = 0;
        while (n_lines < MAX_LINES && field(n_lines, 0) != 32'hFFFF_FFFF) begin
            if (field(n_lines, 5) != 32'd0) begin
                n_need_rsp++;
            end
            n_lines++;
        end
        if (n_lines == 0) begin
            abort_run("No stimulus lines could be read from dcache_stimulus.txt");
        end
        cycle_limit = 30 * n_lines + 100;
        repeat (8) @(negedge clk_i);
        check_value(64'(core_req_ready_o), 64'd0, "core_req_ready_o in reset");
        check_value(64'(core_rsp_valid_o), 64'd0, "core_rsp_valid_o in reset");
        check_value(64'(miss_valid_o), 64'd0, "miss_valid_o in reset");
        check_value(64'(wbuf_write_o), 64'd0, "wbuf_write_o in reset");
        check_value(64'(ctrl_empty_o), 64'd1, "ctrl_empty_o in reset");
        rst_ni = 1'b1;
        for (int k = 0; k < n_lines; k++) begin
            drive_line(k);
        end
        while (!ctrl_empty_o) begin
            @(posedge clk_i);
        end
        check_value(64'(rsp_count), 64'(n_need_rsp), "number of core responses");
        check_value(64'(exp_miss_q.size()), 64'd0, "miss requests still expected");
        check_value(64'(exp_wbuf_q.size()), 64'd0, "write-buffer requests still expected");
        $display("all tests passed");
        $finish;
    end

    // Random back-pressure
    initial begin
        forever begin
            @(negedge clk_i);
            wbuf_ready_i = ($urandom % 4) != 0;
            miss_ready_i = ($urandom % 4) != 0;
        end
    end

    // Refill responder, one miss at a time
    initial begin
        dcache_miss_t m;
        dcache_miss_t e;
        int           delay;
        forever begin
            @(posedge clk_i);
            if (rst_ni && miss_valid_o && miss_ready_i) begin
                m = miss_o;
                if (exp_miss_q.size() == 0) begin
                    abort_run("Miss request seen where a hit was expected");
                end
                e = exp_miss_q.pop_front();
                check_value(64'(m.nline), 64'(e.nline), "miss nline");
                check_value(64'(m.tid), 64'(e.tid), "miss tid");
                check_value(64'(m.word), 64'(e.word), "miss word");
                delay = 1 + int'($urandom % 5);
                repeat (delay) @(posedge clk_i);
                @(negedge clk_i);
                refill_i.nline = m.nline;
                refill_i.tid   = m.tid;
                refill_i.word  = m.word;
                for (int i = 0; i < 4; i++) begin
                    refill_i.line[2'(i)] = shadow[{m.nline, 2'(i)}];
                end
                refill_valid_i = 1'b1;
                @(negedge clk_i);
                refill_valid_i = 1'b0;
            end
        end
    end

    // Write-buffer side; shadow memory follows accepted writes
    always @(posedge clk_i) begin
        dcache_wbuf_t w;
        if (rst_ni && wbuf_write_o && wbuf_ready_i) begin
            if (exp_wbuf_q.size() == 0) begin
                abort_run("Write-buffer request seen with no store pending");
            end
            w = exp_wbuf_q.pop_front();
            check_value(64'(wbuf_o.addr), 64'(w.addr), "wbuf addr");
            check_value(64'(wbuf_o.data), 64'(w.data), "wbuf data");
            check_value(64'(wbuf_o.be), 64'(w.be), "wbuf be");
            for (int b = 0; b < 4; b++) begin
                if (w.be[b]) begin
                    shadow[w.addr[15:2]][8*b +: 8] = w.data[8*b +: 8];
                end
            end
        end
    end

    always @(posedge clk_i) begin
        exp_rsp_t e;
        if (rst_ni && core_rsp_valid_o) begin
            if (exp_rsp_q.size() == 0) begin
                abort_run("Core response seen with no request waiting for one");
            end
            e = exp_rsp_q.pop_front();
            check_value(64'(core_rsp_o.tid), 64'(e.tid), "response tid");
            check_value(64'(core_rsp_o.rdata), 64'(e.rdata), "response rdata");
            if (e.due != 64'd0) begin
                check_value(64'($time), e.due, "hit response time");
            end
            rsp_count++;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            abort_run("Timeout: the run did not finish within the cycle limit");
        end
    end

endmodule

// File: filelist.f
+incdir+.
dcache_pkg.sv
dcache_ram.sv
dcache_req_arbiter.sv
dcache_lookup.sv
dcache_rsp_miss.sv
dcache_ctrl_top.sv
tb_dcache.sv

// File: run.sh
#!/bin/sh
# Build and run the data-cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    -f filelist.f --top-module tb_dcache -o sim_dcache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_dcache)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// File: dcache_stimulus.txt
// op addr wdata be tid need_rsp exp_hit exp_rdata, all hex
// op 0 is a load, 1 a store; stores expect zero data in their response
0 0100 00000000 0 1 1 0 C0DE0040
0 0104 00000000 0 2 1 1 C0DE0041
0 0108 00000000 0 3 1 1 C0DE0042
0 010C 00000000 0 4 1 1 C0DE0043
1 0104 AABBCCDD F 5 1 1 00000000
0 0104 00000000 0 6 1 1 AABBCCDD
1 0108 11223344 3 7 1 1 00000000
0 0108 00000000 0 8 1 1 C0DE3344
1 0200 55667788 C 9 0 0 00000000
0 0200 00000000 0 A 1 0 55660080
0 0100 00000000 0 B 1 0 C0DE0040
0 0300 00000000 0 C 1 0 C0DE00C0
0 0204 00000000 0 D 1 0 C0DE0081
1 0310 DEADBEEF F E 1 0 00000000
0 0310 00000000 0 F 1 0 DEADBEEF
0 0314 00000000 0 0 1 1 C0DE00C5
1 0314 01020304 1 1 1 1 00000000
1 0314 A0B0C0D0 2 2 1 1 00000000
0 0314 00000000 0 3 1 1 C0DEC004
0 0318 00000000 0 4 1 1 C0DE00C6
0 031C 00000000 0 5 0 1 00000000
0 0520 00000000 0 6 1 0 C0DE0148
0 0524 00000000 0 7 1 1 C0DE0149
1 0528 CAFEF00D F 8 1 1 00000000
0 0528 00000000 0 9 1 1 CAFEF00D
0 1234 00000000 0 A 1 0 C0DE048D
0 1230 00000000 0 B 1 1 C0DE048C
0 F0FC 00000000 0 C 1 0 C0DE3C3F
0 F0F0 00000000 0 D 1 1 C0DE3C3C
1 F0F8 12345678 6 E 1 1 00000000
0 F0F8 00000000 0 F 1 1 C034563E
1 0110 99999999 F 0 1 0 00000000
0 0310 00000000 0 1 1 1 DEADBEEF
0 0110 00000000 0 2 1 0 99999999
0 0310 00000000 0 3 1 0 DEADBEEF
0 0100 00000000 0 4 1 0 C0DE0040
0 0108 00000000 0 5 1 1 C0DE3344
0 0104 00000000 0 6 1 1 AABBCCDD
0 0208 00000000 0 7 1 0 C0DE0082
0 0100 00000000 0 8 1 0 C0DE0040
